//--- list.f
design/databus_pkg.sv
design/burst_if.sv
design/burst_merge.sv
design/skid_buffer.sv
design/axi_bridge.sv
design/mem_port_top.sv
test/tb_clock.sv
test/axi_mem_model.sv
test/tb_mem_port.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_mem_port
RTL_TOP   ?= mem_port_top
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_port import databus_pkg::*; ();

  localparam int MAX_CYCLES = 4000;  // 40 bursts of 16 beats at 4 cycles each plus margin

  logic clk;
  logic rst;
  logic rst_d;

  logic [N_PORTS-1:0] unit_valid;
  logic [N_PORTS-1:0] unit_ready;
  logic [N_PORTS-1:0] unit_last;
  addr_t [N_PORTS-1:0] unit_addr;
  data_t [N_PORTS-1:0] unit_wdata;
  strb_t [N_PORTS-1:0] unit_wstrb;
  len_t  [N_PORTS-1:0] unit_len;
  data_t unit_rdata;

  logic axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_wlast;
  logic axi_bvalid, axi_bready, axi_arvalid, axi_arready, axi_rvalid, axi_rready, axi_rlast;
  addr_t axi_awaddr, axi_araddr;
  len_t axi_awlen, axi_arlen;
  logic [2:0] axi_awsize, axi_awprot, axi_arsize, axi_arprot;
  logic [1:0] axi_awburst, axi_arburst;
  logic [3:0] axi_awcache, axi_arcache;
  data_t axi_wdata, axi_rdata;
  strb_t axi_wstrb;

  logic [7:0]  ref_mem [1024];
  addr_t       rd_addr [N_PORTS];
  data_t       exp_rd  [N_PORTS];
  int          beat_cnt [N_PORTS];
  logic [15:0] rng;
  int          data_errs;
  int          prot_errs;
  int          cycles;

  logic [N_PORTS-1:0] wreq;
  logic [N_PORTS-1:0] rreq;
  logic w_gr, r_gr;
  int   exp_w_port, exp_r_port;
  logic w_d1, w_d2, r_d1, r_d2;
  logic aw_wait_q, ar_wait_q, w_axi_open;
  int   w_axi_cnt, aw_len_q, aw_cnt, b_cnt;

  tb_clock #(.PERIOD(20.0)) u_clk (.clk(clk));

  mem_port_top DUT (.*);

  axi_mem_model u_mem (
    .awvalid (axi_awvalid), .awready (axi_awready), .awaddr (axi_awaddr),
    .wvalid  (axi_wvalid),  .wready  (axi_wready),  .wdata  (axi_wdata),
    .wstrb   (axi_wstrb),   .wlast   (axi_wlast),
    .bvalid  (axi_bvalid),  .bready  (axi_bready),
    .arvalid (axi_arvalid), .arready (axi_arready), .araddr (axi_araddr),
    .arlen   (axi_arlen),
    .rvalid  (axi_rvalid),  .rready  (axi_rready),  .rdata  (axi_rdata),
    .rlast   (axi_rlast),
    .clk     (clk),
    .rst     (rst)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      rng = lfsr_next(rng);
      v   = {v[30:0], rng[0]};
    end
  endtask

  function automatic int highest(input logic [N_PORTS-1:0] v);
    int h;
    h = 0;
    for (int i = 0; i < N_PORTS; i++) if (v[i]) h = i;
    return h;
  endfunction

  // Expected read word from the reference bytes
  always_comb begin
    for (int i = 0; i < N_PORTS; i++) begin
      for (int k = 0; k < 4; k++) exp_rd[i][8*k +: 8] = ref_mem[rd_addr[i][9:0] + 10'(k)];
    end
  end

  for (genvar g = 0; g < N_PORTS; g++) begin : g_req
    assign wreq[g] = unit_valid[g] && (unit_wstrb[g] != '0);
    assign rreq[g] = unit_valid[g] && (unit_wstrb[g] == '0);
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      w_gr <= 1'b0;
      r_gr <= 1'b0;
      exp_w_port <= 0;
      exp_r_port <= 0;
      {w_d1, w_d2, r_d1, r_d2, aw_wait_q, ar_wait_q, w_axi_open} <= '0;
      w_axi_cnt <= 0;
      aw_len_q  <= 0;
      aw_cnt    <= 0;
      b_cnt     <= 0;
      for (int i = 0; i < N_PORTS; i++) beat_cnt[i] <= 0;
    end else begin
      // Highest requesting port wins and holds until last
      if (!w_gr && |wreq) begin
        w_gr <= 1'b1;
        exp_w_port <= highest(wreq);
      end else if (w_gr && unit_ready[exp_w_port] && unit_last[exp_w_port]) begin
        w_gr <= 1'b0;
      end
      if (!r_gr && |rreq) begin
        r_gr <= 1'b1;
        exp_r_port <= highest(rreq);
      end else if (r_gr && unit_ready[exp_r_port] && unit_last[exp_r_port]) begin
        r_gr <= 1'b0;
      end
      w_d1 <= !w_gr && |wreq;
      w_d2 <= w_d1;
      r_d1 <= !r_gr && |rreq;
      r_d2 <= r_d1;
      aw_wait_q <= axi_awvalid && !axi_awready;
      ar_wait_q <= axi_arvalid && !axi_arready;
      if (axi_awvalid && axi_awready) begin
        w_axi_open <= 1'b1;
        w_axi_cnt  <= 0;
        aw_len_q   <= int'(unit_len[exp_w_port]);
        aw_cnt     <= aw_cnt + 1;
      end
      if (axi_wvalid && axi_wready) begin
        w_axi_cnt <= w_axi_cnt + 1;
        if (axi_wlast) w_axi_open <= 1'b0;
      end
      if (axi_bvalid && axi_bready) b_cnt <= b_cnt + 1;
      for (int i = 0; i < N_PORTS; i++) begin
        if (unit_valid[i] && unit_ready[i]) beat_cnt[i] <= unit_last[i] ? 0 : beat_cnt[i] + 1;
      end
    end
  end

  for (genvar g = 0; g < N_PORTS; g++) begin : g_chk
    assert property (@(posedge clk) disable iff (rst)
      rreq[g] && unit_ready[g] |-> unit_rdata == exp_rd[g])
      else begin
        data_errs++;
        $display("mismatch at %0t: unit_rdata port %0d expected %h got %h",
                 $time, g, $sampled(exp_rd[g]), $sampled(unit_rdata));
      end
    assert property (@(posedge clk) disable iff (rst)
      unit_valid[g] && unit_ready[g] && unit_last[g] |-> beat_cnt[g] == int'(unit_len[g]))
      else begin
        prot_errs++;
        $display("mismatch at %0t: beats at unit_last port %0d expected %0d got %0d",
                 $time, g, int'($sampled(unit_len[g])) + 1, $sampled(beat_cnt[g]) + 1);
      end
    assert property (@(posedge clk) disable iff (rst)
      unit_valid[g] && unit_ready[g] && !unit_last[g] |-> beat_cnt[g] < int'(unit_len[g]))
      else begin
        prot_errs++;
        $display("Port %0d burst ran past len without unit_last at %0t", g, $time);
      end
  end

  assert property (@(posedge clk) (rst || rst_d) |->
    unit_ready == '0 && unit_last == '0 && !axi_awvalid && !axi_arvalid && !axi_wvalid)
    else begin
      prot_errs++;
      $display("Outputs not idle during or right after reset at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (rst)
    axi_awvalid |-> axi_awaddr == unit_addr[exp_w_port])
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_awaddr expected %h got %h", $time,
               $sampled(unit_addr[exp_w_port]), $sampled(axi_awaddr));
    end
  assert property (@(posedge clk) disable iff (rst)
    axi_awvalid |-> axi_awlen == unit_len[exp_w_port])
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_awlen expected %0d got %0d", $time,
               $sampled(unit_len[exp_w_port]), $sampled(axi_awlen));
    end
  // Size 2, INCR, cache 2, prot 2
  assert property (@(posedge clk) disable iff (rst) axi_awvalid |->
    {axi_awsize, axi_awburst, axi_awcache, axi_awprot} == {3'd2, 2'd1, 4'd2, 3'd2})
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_aw size/burst/cache/prot expected %h got %h", $time,
               {3'd2, 2'd1, 4'd2, 3'd2},
               $sampled({axi_awsize, axi_awburst, axi_awcache, axi_awprot}));
    end

  assert property (@(posedge clk) disable iff (rst)
    axi_arvalid |-> axi_araddr == unit_addr[exp_r_port])
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_araddr expected %h got %h", $time,
               $sampled(unit_addr[exp_r_port]), $sampled(axi_araddr));
    end
  assert property (@(posedge clk) disable iff (rst)
    axi_arvalid |-> axi_arlen == unit_len[exp_r_port])
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_arlen expected %0d got %0d", $time,
               $sampled(unit_len[exp_r_port]), $sampled(axi_arlen));
    end
  assert property (@(posedge clk) disable iff (rst) axi_arvalid |->
    {axi_arsize, axi_arburst, axi_arcache, axi_arprot} == {3'd2, 2'd1, 4'd2, 3'd2})
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_ar size/burst/cache/prot expected %h got %h", $time,
               {3'd2, 2'd1, 4'd2, 3'd2},
               $sampled({axi_arsize, axi_arburst, axi_arcache, axi_arprot}));
    end

  assert property (@(posedge clk) disable iff (rst) aw_wait_q |-> axi_awvalid)
    else begin
      prot_errs++;
      $display("axi_awvalid dropped before awready at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst) ar_wait_q |-> axi_arvalid)
    else begin
      prot_errs++;
      $display("axi_arvalid dropped before arready at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
    (w_d1 |-> !axi_awvalid) and (w_d2 |-> axi_awvalid))
    else begin
      prot_errs++;
      $display("Write request to axi_awvalid was not 2 cycles at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
    (r_d1 |-> !axi_arvalid) and (r_d2 |-> axi_arvalid))
    else begin
      prot_errs++;
      $display("Read request to axi_arvalid was not 2 cycles at %0t", $time);
    end
  // W beats only between an accepted address and its wlast
  assert property (@(posedge clk) disable iff (rst) axi_wvalid |-> w_axi_open)
    else begin
      prot_errs++;
      $display("W beat offered outside an accepted write burst at %0t", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
    axi_wvalid && axi_wready |-> axi_wlast == (w_axi_cnt == aw_len_q))
    else begin
      prot_errs++;
      $display("mismatch at %0t: axi_wlast expected %b got %b", $time,
               $sampled(w_axi_cnt == aw_len_q), $sampled(axi_wlast));
    end

  task automatic next_beat(input strb_t strb_fix, output data_t d, output strb_t s);
    logic [31:0] v;
    take_bits(32, v);
    d = v;
    s = strb_fix;
    while (s == '0) begin  // Random but never zero
      take_bits(4, v);
      s = v[3:0];
    end
  endtask

  task automatic write_burst(input int p, input addr_t addr, input int len, input strb_t strb_fix);
    addr_t a;
    data_t d;
    strb_t s;
    a = addr;
    next_beat(strb_fix, d, s);
    @(posedge clk);
    unit_valid[p] <= 1'b1;
    unit_addr[p]  <= addr;
    unit_len[p]   <= len_t'(len);
    unit_wdata[p] <= d;
    unit_wstrb[p] <= s;
    forever begin
      @(posedge clk);
      if (unit_ready[p]) begin
        for (int k = 0; k < 4; k++) if (s[k]) ref_mem[a[9:0] + 10'(k)] = d[8*k +: 8];
        a = a + 4;
        if (unit_last[p]) break;
        next_beat(strb_fix, d, s);
        unit_wdata[p] <= d;
        unit_wstrb[p] <= s;
      end
    end
    unit_valid[p] <= 1'b0;
    unit_wstrb[p] <= '0;
  endtask

  task automatic read_burst(input int p, input addr_t addr, input int len);
    @(posedge clk);
    unit_valid[p] <= 1'b1;
    unit_addr[p]  <= addr;
    unit_len[p]   <= len_t'(len);
    unit_wstrb[p] <= '0;
    rd_addr[p] = addr;
    forever begin
      @(posedge clk);
      if (unit_ready[p]) begin
        rd_addr[p] = rd_addr[p] + 4;
        if (unit_last[p]) break;
      end
    end
    unit_valid[p] <= 1'b0;
  endtask

  // Memory writes land only after the B response
  task automatic wait_writes_done();
    @(posedge clk);
    while (b_cnt != aw_cnt) @(posedge clk);
  endtask

  task automatic random_burst();
    logic [31:0] p;
    logic [31:0] dir;
    logic [31:0] len;
    logic [31:0] w;
    take_bits(1, p);
    take_bits(1, dir);
    take_bits(4, len);
    take_bits(8, w);
    if (w + len > 255) w = 255 - len;
    if (dir[0]) begin
      write_burst(int'(p), addr_t'(w * 4), int'(len), '0);
      wait_writes_done();
    end else begin
      read_burst(int'(p), addr_t'(w * 4), int'(len));
    end
  endtask

  always @(posedge clk) begin
    rst_d  <= rst;
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    rst = 1'b1;
    rst_d = 1'b1;
    rng = 16'd3;
    cycles = 0;
    data_errs = 0;
    prot_errs = 0;
    unit_valid = '0;
    unit_addr = '0;
    unit_wdata = '0;
    unit_wstrb = '0;
    unit_len = '0;
    for (int i = 0; i < N_PORTS; i++) rd_addr[i] = '0;
    for (int i = 0; i < 256; i++) begin
      {ref_mem[4*i+3], ref_mem[4*i+2], ref_mem[4*i+1], ref_mem[4*i]} =
        {8'(i), 8'(~i), 8'(i * 7), 8'(i) ^ 8'h5A};
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    write_burst(0, 32'h40, 3, 4'hF);
    wait_writes_done();
    read_burst(0, 32'h40, 3);

    write_burst(1, 32'h80, 2, 4'b0101);
    write_burst(0, 32'h84, 0, 4'b1000);
    wait_writes_done();
    read_burst(1, 32'h80, 3);

    fork
      write_burst(0, 32'h100, 3, '0);
      write_burst(1, 32'h200, 3, '0);
    join
    wait_writes_done();
    fork
      read_burst(0, 32'h100, 3);
      read_burst(1, 32'h200, 3);
    join

    fork
      read_burst(0, 32'h100, 3);
      write_burst(1, 32'h300, 7, '0);
    join
    wait_writes_done();

    repeat (24) random_burst();
    repeat (5) @(posedge clk);

    $display("Errors: %0d data, %0d protocol", data_errs, prot_errs);
    if (data_errs == 0 && prot_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

// AXI4 slave with 256 words and random stalls on every channel
module axi_mem_model import databus_pkg::*; (
  input  logic  awvalid,
  output logic  awready,
  input  addr_t awaddr,
  input  logic  wvalid,
  output logic  wready,
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wlast,
  output logic  bvalid,
  input  logic  bready,
  input  logic  arvalid,
  output logic  arready,
  input  addr_t araddr,
  input  len_t  arlen,
  output logic  rvalid,
  input  logic  rready,
  output data_t rdata,
  output logic  rlast,
  input  logic  clk,
  input  logic  rst
);

  data_t       mem [256];
  logic [15:0] lfsr;
  logic        w_busy;
  logic        r_busy;
  logic [7:0]  w_idx;
  logic [7:0]  r_idx;
  int          r_left;   // Beats still to present

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  always @(posedge clk or posedge rst) begin
    logic b_aw;
    logic b_w;
    logic b_ar;
    logic b_r;
    if (rst) begin
      lfsr = 16'd3;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rlast   <= 1'b0;
      w_busy  <= 1'b0;
      r_busy  <= 1'b0;
      w_idx   <= '0;
      r_idx   <= '0;
      r_left  <= 0;
      for (int i = 0; i < 256; i++) begin
        mem[i] <= {8'(i), 8'(~i), 8'(i * 7), 8'(i) ^ 8'h5A};  // Same fill as the testbench
      end
    end else begin
      take_bit(b_aw);
      take_bit(b_w);
      take_bit(b_ar);
      take_bit(b_r);
      if (bvalid && bready) bvalid <= 1'b0;

      if (!w_busy) begin
        awready <= awvalid && !awready && b_aw;
        if (awvalid && awready) begin
          w_busy  <= 1'b1;
          w_idx   <= awaddr[9:2];
          awready <= 1'b0;
        end
      end else begin
        wready <= b_w;
        if (wvalid && wready) begin
          for (int k = 0; k < STRB_W; k++) begin
            if (wstrb[k]) mem[w_idx][8*k +: 8] <= wdata[8*k +: 8];
          end
          w_idx <= w_idx + 8'd1;
          if (wlast) begin
            w_busy <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b1;
          end
        end
      end

      if (!r_busy) begin
        arready <= arvalid && !arready && b_ar;
        if (arvalid && arready) begin
          r_busy  <= 1'b1;
          r_idx   <= araddr[9:2];
          r_left  <= int'(arlen) + 1;
          arready <= 1'b0;
        end
      end else begin
        if (rvalid && rready) begin
          rvalid <= 1'b0;
          if (rlast) r_busy <= 1'b0;
        end
        if ((!rvalid || rready) && r_left != 0 && b_r) begin
          rvalid <= 1'b1;
          rdata  <= mem[r_idx];
          rlast  <= (r_left == 1);
          r_idx  <= r_idx + 8'd1;
          r_left <= r_left - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD = 20.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

//--- design/mem_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_top import databus_pkg::*; (
  input  logic [N_PORTS-1:0] unit_valid,
  output logic [N_PORTS-1:0] unit_ready,
  output logic [N_PORTS-1:0] unit_last,
  input  addr_t [N_PORTS-1:0] unit_addr,
  input  data_t [N_PORTS-1:0] unit_wdata,
  input  strb_t [N_PORTS-1:0] unit_wstrb,
  input  len_t  [N_PORTS-1:0] unit_len,
  output data_t               unit_rdata,

  output logic       axi_awvalid,
  input  logic       axi_awready,
  output addr_t      axi_awaddr,
  output len_t       axi_awlen,
  output logic [2:0] axi_awsize,
  output logic [1:0] axi_awburst,
  output logic [3:0] axi_awcache,
  output logic [2:0] axi_awprot,
  output logic       axi_wvalid,
  input  logic       axi_wready,
  output data_t      axi_wdata,
  output strb_t      axi_wstrb,
  output logic       axi_wlast,
  input  logic       axi_bvalid,
  output logic       axi_bready,
  output logic       axi_arvalid,
  input  logic       axi_arready,
  output addr_t      axi_araddr,
  output len_t       axi_arlen,
  output logic [2:0] axi_arsize,
  output logic [1:0] axi_arburst,
  output logic [3:0] axi_arcache,
  output logic [2:0] axi_arprot,
  input  logic       axi_rvalid,
  output logic       axi_rready,
  input  data_t      axi_rdata,
  input  logic       axi_rlast,

  input  logic       clk,
  input  logic       rst
);

  databus_if  dbus [N_PORTS] ();
  wr_burst_if wr_ch ();
  rd_burst_if rd_ch ();

  for (genvar g = 0; g < N_PORTS; g++) begin : g_unit
    assign dbus[g].valid = unit_valid[g];
    assign dbus[g].addr  = unit_addr[g];
    assign dbus[g].wdata = unit_wdata[g];
    assign dbus[g].wstrb = unit_wstrb[g];
    assign dbus[g].len   = unit_len[g];
    assign unit_ready[g] = dbus[g].ready;
    assign unit_last[g]  = dbus[g].last;
  end

  assign unit_rdata = dbus[0].rdata;  // Broadcast to every port

  burst_merge u_merge (
    .units (dbus),
    .wr    (wr_ch),
    .rd    (rd_ch),
    .clk   (clk),
    .rst   (rst)
  );

  axi_bridge u_bridge (
    .wr          (wr_ch),
    .rd          (rd_ch),
    .axi_awvalid (axi_awvalid),
    .axi_awready (axi_awready),
    .axi_awaddr  (axi_awaddr),
    .axi_awlen   (axi_awlen),
    .axi_awsize  (axi_awsize),
    .axi_awburst (axi_awburst),
    .axi_awcache (axi_awcache),
    .axi_awprot  (axi_awprot),
    .axi_wvalid  (axi_wvalid),
    .axi_wready  (axi_wready),
    .axi_wdata   (axi_wdata),
    .axi_wstrb   (axi_wstrb),
    .axi_wlast   (axi_wlast),
    .axi_bvalid  (axi_bvalid),
    .axi_bready  (axi_bready),
    .axi_arvalid (axi_arvalid),
    .axi_arready (axi_arready),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .axi_arsize  (axi_arsize),
    .axi_arburst (axi_arburst),
    .axi_arcache (axi_arcache),
    .axi_arprot  (axi_arprot),
    .axi_rvalid  (axi_rvalid),
    .axi_rready  (axi_rready),
    .axi_rdata   (axi_rdata),
    .axi_rlast   (axi_rlast),
    .clk         (clk),
    .rst         (rst)
  );

endmodule

`default_nettype wire

//--- design/axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bridge import databus_pkg::*; (
  wr_burst_if.dst    wr,
  rd_burst_if.dst    rd,

  output logic       axi_awvalid,
  input  logic       axi_awready,
  output addr_t      axi_awaddr,
  output len_t       axi_awlen,
  output logic [2:0] axi_awsize,
  output logic [1:0] axi_awburst,
  output logic [3:0] axi_awcache,
  output logic [2:0] axi_awprot,

  output logic       axi_wvalid,
  input  logic       axi_wready,
  output data_t      axi_wdata,
  output strb_t      axi_wstrb,
  output logic       axi_wlast,

  input  logic       axi_bvalid,
  output logic       axi_bready,

  output logic       axi_arvalid,
  input  logic       axi_arready,
  output addr_t      axi_araddr,
  output len_t       axi_arlen,
  output logic [2:0] axi_arsize,
  output logic [1:0] axi_arburst,
  output logic [3:0] axi_arcache,
  output logic [2:0] axi_arprot,

  input  logic       axi_rvalid,
  output logic       axi_rready,
  input  data_t      axi_rdata,
  input  logic       axi_rlast,

  input  logic       clk,
  input  logic       rst
);

  typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} seq_t;

  // W beat plus its AXI wlast
  typedef struct packed {
    wbeat_t beat;
    logic   last;
  } wside_t;

  seq_t   wstate;
  seq_t   rstate;
  len_t   wcnt;
  logic   wlast_beat;

  logic   w_in_valid;
  logic   w_in_ready;
  wside_t w_in_data;
  logic   w_out_valid;
  wside_t w_out_data;

  logic   r_in_valid;
  logic   r_in_ready;
  rbeat_t r_in_data;
  logic   r_out_valid;
  rbeat_t r_out_data;

  assign axi_awaddr  = wr.addr;   // Held by the unit until the first beat
  assign axi_awlen   = wr.len;
  assign axi_awsize  = AXI_SIZE_WORD;
  assign axi_awburst = AXI_BURST_INCR;
  assign axi_awcache = AXI_CACHE_BUF;
  assign axi_awprot  = AXI_PROT_DATA;

  assign axi_araddr  = rd.addr;
  assign axi_arlen   = rd.len;
  assign axi_arsize  = AXI_SIZE_WORD;
  assign axi_arburst = AXI_BURST_INCR;
  assign axi_arcache = AXI_CACHE_BUF;
  assign axi_arprot  = AXI_PROT_DATA;

  assign axi_bready = 1'b1;   // Responses dropped

  assign wlast_beat = (wcnt == wr.len);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wstate      <= ST_IDLE;
      axi_awvalid <= 1'b0;
      wcnt        <= '0;
    end else begin
      case (wstate)
        ST_IDLE: if (wr.valid) begin
          axi_awvalid <= 1'b1;
          wstate      <= ST_ADDR;
        end
        ST_ADDR: if (axi_awready) begin
          axi_awvalid <= 1'b0;
          wstate      <= ST_DATA;
        end
        ST_DATA: if (wr.valid && wr.ready) begin
          if (wlast_beat) begin
            wcnt   <= '0;
            wstate <= ST_IDLE;
          end else begin
            wcnt <= wcnt + 1'b1;
          end
        end
        default: wstate <= ST_IDLE;
      endcase
    end
  end

  assign w_in_valid = (wstate == ST_DATA) && wr.valid;
  assign wr.ready   = (wstate == ST_DATA) && w_in_ready;
  assign wr.last    = wr.ready && wlast_beat;
  assign w_in_data  = '{beat: '{data: wr.data, strb: wr.strb}, last: wlast_beat};

  skid_buffer #(.payload_t(wside_t)) u_w_skid (
    .in_valid  (w_in_valid),
    .in_ready  (w_in_ready),
    .in_data   (w_in_data),
    .out_valid (w_out_valid),
    .out_ready (axi_wready),
    .out_data  (w_out_data),
    .clk       (clk),
    .rst       (rst)
  );

  assign axi_wvalid = w_out_valid;
  assign axi_wdata  = w_out_data.beat.data;
  assign axi_wstrb  = w_out_data.beat.strb;
  assign axi_wlast  = w_out_data.last;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rstate      <= ST_IDLE;
      axi_arvalid <= 1'b0;
    end else begin
      case (rstate)
        ST_IDLE: if (rd.valid) begin
          axi_arvalid <= 1'b1;
          rstate      <= ST_ADDR;
        end
        ST_ADDR: if (axi_arready) begin
          axi_arvalid <= 1'b0;
          rstate      <= ST_DATA;
        end
        // Done once the final beat leaves the skid
        ST_DATA: if (rd.valid && r_out_valid && r_out_data.last) rstate <= ST_IDLE;
        default: rstate <= ST_IDLE;
      endcase
    end
  end

  assign r_in_valid = (rstate == ST_DATA) && axi_rvalid;
  assign axi_rready = (rstate == ST_DATA) && r_in_ready;
  assign r_in_data  = '{data: axi_rdata, last: axi_rlast};

  skid_buffer #(.payload_t(rbeat_t)) u_r_skid (
    .in_valid  (r_in_valid),
    .in_ready  (r_in_ready),
    .in_data   (r_in_data),
    .out_valid (r_out_valid),
    .out_ready (rd.valid),
    .out_data  (r_out_data),
    .clk       (clk),
    .rst       (rst)
  );

  assign rd.ready = r_out_valid;
  assign rd.data  = r_out_data.data;
  assign rd.last  = r_out_valid && r_out_data.last;

endmodule

`default_nettype wire

//--- design/skid_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buffer import databus_pkg::*; #(
  parameter type payload_t = wbeat_t
) (
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data,
  input  logic     clk,
  input  logic     rst
);

  payload_t skid_data;
  logic     stored;     // Skid register holds a beat
  logic     in_xfer;
  logic     out_free;   // Main register can take a new beat

  assign in_xfer  = in_valid && in_ready;
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
      stored    <= 1'b0;
      in_ready  <= 1'b1;
    end else if (stored) begin
      // out_valid stays high while draining
      if (out_ready) begin
        stored   <= 1'b0;
        in_ready <= 1'b1;
      end
    end else if (out_free) begin
      out_valid <= in_xfer;
    end else if (in_xfer) begin
      stored   <= 1'b1;   // Caught while output stalled
      in_ready <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stored) begin
      if (out_ready) begin
        out_data <= skid_data;
      end
    end else if (out_free) begin
      if (in_xfer) begin
        out_data <= in_data;
      end
    end else if (in_xfer) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- design/burst_merge.sv
`timescale 1ns/1ps
`default_nettype none

module burst_merge import databus_pkg::*; (
  databus_if.merge units [N_PORTS],
  wr_burst_if.src  wr,
  rd_burst_if.src  rd,
  input  logic     clk,
  input  logic     rst
);

  logic [N_PORTS-1:0] st_valid;
  addr_t              st_addr  [N_PORTS];
  data_t              st_wdata [N_PORTS];
  strb_t              st_wstrb [N_PORTS];
  len_t               st_len   [N_PORTS];

  logic      w_run;
  logic      r_run;
  port_idx_t w_idx;
  port_idx_t r_idx;

  logic      w_req_valid;
  logic      r_req_valid;
  port_idx_t w_req;
  port_idx_t r_req;

  for (genvar g = 0; g < N_PORTS; g++) begin : g_port
    logic w_sel;
    logic r_sel;

    assign st_valid[g] = units[g].valid;
    assign st_addr[g]  = units[g].addr;
    assign st_wdata[g] = units[g].wdata;
    assign st_wstrb[g] = units[g].wstrb;
    assign st_len[g]   = units[g].len;

    assign w_sel = w_run && (w_idx == port_idx_t'(g));
    assign r_sel = r_run && (r_idx == port_idx_t'(g));

    // Only the granted port sees ready and last
    assign units[g].ready = (w_sel && wr.ready) || (r_sel && rd.ready);
    assign units[g].last  = (w_sel && wr.last) || (r_sel && rd.last);
    assign units[g].rdata = rd.data;
  end

  // Highest index wins
  always_comb begin
    w_req_valid = 1'b0;
    r_req_valid = 1'b0;
    w_req       = '0;
    r_req       = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (st_valid[i] && |st_wstrb[i]) begin
        w_req_valid = 1'b1;
        w_req       = port_idx_t'(i);
      end else if (st_valid[i] && !(w_run && w_idx == port_idx_t'(i))) begin
        // A zero-strobe beat inside a write burst is not a read
        r_req_valid = 1'b1;
        r_req       = port_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      w_run <= 1'b0;
      r_run <= 1'b0;
      w_idx <= '0;
      r_idx <= '0;
    end else begin
      if (!w_run && w_req_valid) begin
        w_run <= 1'b1;
        w_idx <= w_req;
      end else if (w_run && wr.valid && wr.ready && wr.last) begin
        w_run <= 1'b0;
      end

      if (!r_run && r_req_valid) begin
        r_run <= 1'b1;
        r_idx <= r_req;
      end else if (r_run && rd.valid && rd.ready && rd.last) begin
        r_run <= 1'b0;
      end
    end
  end

  assign wr.valid = w_run && st_valid[w_idx];
  assign wr.addr  = st_addr[w_idx];
  assign wr.data  = st_wdata[w_idx];
  assign wr.strb  = st_wstrb[w_idx];
  assign wr.len   = st_len[w_idx];

  assign rd.valid = r_run && st_valid[r_idx];
  assign rd.addr  = st_addr[r_idx];
  assign rd.len   = st_len[r_idx];

endmodule

`default_nettype wire

//--- design/burst_if.sv
`timescale 1ns/1ps
`default_nettype none

// Per-unit databus with direction chosen by wstrb
interface databus_if import databus_pkg::*; ();
  logic  valid;
  logic  ready;
  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  data_t rdata;
  len_t  len;
  logic  last;

  modport unit  (output valid, addr, wdata, wstrb, len, input ready, rdata, last);
  modport merge (input valid, addr, wdata, wstrb, len, output ready, rdata, last);
endinterface

interface wr_burst_if import databus_pkg::*; ();
  logic  valid;
  logic  ready;
  addr_t addr;
  data_t data;
  strb_t strb;
  len_t  len;
  logic  last;

  modport src (output valid, addr, data, strb, len, input ready, last);
  modport dst (input valid, addr, data, strb, len, output ready, last);
endinterface

interface rd_burst_if import databus_pkg::*; ();
  logic  valid;
  logic  ready;
  addr_t addr;
  data_t data;
  len_t  len;
  logic  last;

  modport src (output valid, addr, len, input ready, data, last);
  modport dst (input valid, addr, len, output ready, data, last);
endinterface

`default_nettype wire

//--- design/databus_pkg.sv
`default_nettype none

package databus_pkg;

  localparam int N_PORTS = 2;    // I/O units on the databus
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int LEN_W   = 8;     // len+1 beats per burst
  localparam int PORT_W  = 1;

  // Fixed AXI attributes
  localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
  localparam logic [1:0] AXI_BURST_INCR = 2'd1;
  localparam logic [3:0] AXI_CACHE_BUF  = 4'd2;
  localparam logic [2:0] AXI_PROT_DATA  = 3'd2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [PORT_W-1:0] port_idx_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } wbeat_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } rbeat_t;

endpackage

`default_nettype wire
